// ==== source/axi_mem_pkg.sv ====
package axi_mem_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int ADDR_W     = 64;
    localparam int DATA_W     = 64;
    localparam int INST_W     = 32;
    localparam int STRB_W     = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [3:0]        axi_id_t;
    typedef logic [7:0]        axi_len_t;
    typedef logic [2:0]        axi_size_t;
    typedef logic [1:0]        axi_burst_t;
    typedef logic [1:0]        axi_resp_t;

    // ==============================
    // AXI codes
    // ==============================
    localparam axi_id_t    ID_RAM      = 4'd0;
    localparam axi_id_t    ID_INST     = 4'd1;
    localparam axi_len_t   LEN_SINGLE  = 8'd0;  // one beat
    localparam axi_size_t  SIZE_DWORD  = 3'd3;
    localparam axi_burst_t BURST_INCR  = 2'd1;
    localparam axi_resp_t  RESP_OKAY   = 2'd0;
    localparam axi_resp_t  RESP_SLVERR = 2'd2;

    // memory geometry
    localparam int RAM_WORDS  = 256;
    localparam int INST_WORDS = 64;
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);   // addr bits 10..3
    localparam int INST_IDX_W = $clog2(INST_WORDS);  // addr bits 7..2
    localparam int RAM_LSB    = 3;
    localparam int INST_LSB   = 2;

    typedef enum logic [1:0] {WR_IDLE, WR_INFO, WR_RESP} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;
    typedef enum logic [1:0] {BR_IDLE, BR_ADDR, BR_WAIT_RESP, BR_DONE} bridge_state_t;

endpackage

// ==== source/core_axi_bridge.sv ====
module core_axi_bridge (
    input  logic                    clk,
    input  logic                    rst,

    // core side
    input  logic                    req,
    input  logic                    req_write,
    input  axi_mem_pkg::axi_id_t    req_id,
    input  axi_mem_pkg::axi_size_t  req_size,
    input  axi_mem_pkg::addr_t      req_addr,
    input  axi_mem_pkg::data_t      req_wdata,
    input  axi_mem_pkg::strb_t      req_strb,
    output logic                    busy,
    output logic                    done,
    output axi_mem_pkg::data_t      rdata,
    output axi_mem_pkg::axi_resp_t  resp,

    // write address / data / response
    output axi_mem_pkg::axi_id_t    aw_id,
    output axi_mem_pkg::addr_t      aw_addr,
    output axi_mem_pkg::axi_len_t   aw_len,
    output axi_mem_pkg::axi_size_t  aw_size,
    output axi_mem_pkg::axi_burst_t aw_burst,
    output logic                    aw_valid,
    input  logic                    aw_ready,
    output axi_mem_pkg::data_t      w_data,
    output axi_mem_pkg::strb_t      w_strb,
    output logic                    w_last,
    output logic                    w_valid,
    input  logic                    w_ready,
    input  axi_mem_pkg::axi_resp_t  b_resp,
    input  logic                    b_valid,
    output logic                    b_ready,

    // read address / data
    output axi_mem_pkg::axi_id_t    ar_id,
    output axi_mem_pkg::addr_t      ar_addr,
    output axi_mem_pkg::axi_len_t   ar_len,
    output axi_mem_pkg::axi_size_t  ar_size,
    output axi_mem_pkg::axi_burst_t ar_burst,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    input  axi_mem_pkg::data_t      r_data,
    input  axi_mem_pkg::axi_resp_t  r_resp,
    input  logic                    r_last,
    input  logic                    r_valid,
    output logic                    r_ready
);
    import axi_mem_pkg::*;

    bridge_state_t state;
    logic          wr_q;
    axi_id_t       id_q;
    axi_size_t     size_q;
    addr_t         addr_q;
    data_t         wdata_q;
    strb_t         strb_q;
    data_t         rdata_q;
    axi_resp_t     resp_q;
    logic          take_req;
    logic          addr_fire;
    logic          resp_fire;

    assign take_req  = req && (state == BR_IDLE || state == BR_DONE);
    assign addr_fire = wr_q ? (aw_valid && aw_ready && w_ready) : (ar_valid && ar_ready);
    assign resp_fire = wr_q ? (b_valid && b_ready) : (r_valid && r_ready && r_last);

    // ==============================
    // request FSM
    // ==============================
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= BR_IDLE;
        end else begin
            case (state)
                BR_IDLE:      if (take_req) state <= BR_ADDR;
                BR_ADDR:      if (addr_fire) state <= BR_WAIT_RESP;
                BR_WAIT_RESP: if (resp_fire) state <= BR_DONE;
                BR_DONE:      state <= take_req ? BR_ADDR : BR_IDLE;  // back to back
                default:      state <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            wr_q    <= req_write;
            id_q    <= req_id;
            size_q  <= req_size;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
        end
        if (state == BR_WAIT_RESP && resp_fire) begin
            rdata_q <= wr_q ? '0 : r_data;
            resp_q  <= wr_q ? b_resp : r_resp;
        end
    end

    // channel drive
    assign aw_id    = id_q;
    assign aw_addr  = addr_q;
    assign aw_len   = LEN_SINGLE;
    assign aw_size  = size_q;
    assign aw_burst = BURST_INCR;
    assign aw_valid = (state == BR_ADDR) && wr_q;
    assign w_data   = wdata_q;
    assign w_strb   = strb_q;
    assign w_last   = 1'b1;          // single beat
    assign w_valid  = (state == BR_ADDR) && wr_q;
    assign b_ready  = (state == BR_WAIT_RESP) && wr_q;

    assign ar_id    = id_q;
    assign ar_addr  = addr_q;
    assign ar_len   = LEN_SINGLE;
    assign ar_size  = size_q;
    assign ar_burst = BURST_INCR;
    assign ar_valid = (state == BR_ADDR) && !wr_q;
    assign r_ready  = (state == BR_WAIT_RESP) && !wr_q;

    assign busy  = (state == BR_ADDR) || (state == BR_WAIT_RESP);
    assign done  = (state == BR_DONE);
    assign rdata = rdata_q;
    assign resp  = resp_q;

endmodule

// ==== source/axi_mem_slave.sv ====
module axi_mem_slave (
    input  logic                    clk,
    input  logic                    rst,

    // write address / data / response
    input  axi_mem_pkg::axi_id_t    aw_id,
    input  axi_mem_pkg::addr_t      aw_addr,
    input  axi_mem_pkg::axi_len_t   aw_len,
    input  axi_mem_pkg::axi_size_t  aw_size,
    input  axi_mem_pkg::axi_burst_t aw_burst,
    input  logic                    aw_valid,
    output logic                    aw_ready,
    input  axi_mem_pkg::data_t      w_data,
    input  axi_mem_pkg::strb_t      w_strb,
    input  logic                    w_last,
    input  logic                    w_valid,
    output logic                    w_ready,
    output axi_mem_pkg::axi_resp_t  b_resp,
    output logic                    b_valid,
    input  logic                    b_ready,

    // read address / data
    input  axi_mem_pkg::axi_id_t    ar_id,
    input  axi_mem_pkg::addr_t      ar_addr,
    input  axi_mem_pkg::axi_len_t   ar_len,
    input  axi_mem_pkg::axi_size_t  ar_size,
    input  axi_mem_pkg::axi_burst_t ar_burst,
    input  logic                    ar_valid,
    output logic                    ar_ready,
    output axi_mem_pkg::data_t      r_data,
    output axi_mem_pkg::axi_resp_t  r_resp,
    output logic                    r_last,
    output logic                    r_valid,
    input  logic                    r_ready,

    // memory side
    output logic                    ram_rd_en,
    output logic                    inst_rd_en,
    output axi_mem_pkg::addr_t      rd_addr,
    input  axi_mem_pkg::data_t      ram_rdata,
    input  axi_mem_pkg::inst_t      inst_rdata,
    output logic                    ram_wr_en,
    output axi_mem_pkg::addr_t      wr_addr,
    output axi_mem_pkg::data_t      wr_data,
    output axi_mem_pkg::strb_t      wr_strb
);
    import axi_mem_pkg::*;

    wr_state_t wr_state;
    rd_state_t rd_state;
    logic      aw_fire;
    logic      ar_fire;
    logic      wr_ok;
    logic      rd_ok;
    logic      wr_legal;
    logic      rd_legal;
    axi_id_t   rd_id;
    addr_t     wr_addr_q;
    data_t     wr_data_q;
    strb_t     wr_strb_q;
    addr_t     rd_addr_q;
    logic      rd_ram;
    logic      rd_inst;

    // ==============================
    // write side
    // ==============================
    // aw and w only accepted together
    assign aw_ready = (wr_state == WR_IDLE) && aw_valid && w_valid;
    assign w_ready  = aw_ready;
    assign aw_fire  = aw_valid && aw_ready;
    assign wr_ok    = (aw_len == LEN_SINGLE) && (aw_size == SIZE_DWORD) &&
                      (aw_burst == BURST_INCR) && (aw_id == ID_RAM) && w_last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_state  <= WR_IDLE;
            wr_legal  <= 1'b0;
            ram_wr_en <= 1'b0;
        end else begin
            ram_wr_en <= (wr_state == WR_INFO) && wr_legal;  // single pulse on entering resp
            case (wr_state)
                WR_IDLE: begin
                    if (aw_fire) begin
                        wr_state <= WR_INFO;
                        wr_legal <= wr_ok;
                    end
                end
                WR_INFO: wr_state <= WR_RESP;
                WR_RESP: if (b_valid && b_ready) wr_state <= WR_IDLE;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr_q <= aw_addr;
            wr_data_q <= w_data;
            wr_strb_q <= w_strb;
        end
    end

    assign b_valid = (wr_state == WR_RESP);
    assign b_resp  = wr_legal ? RESP_OKAY : RESP_SLVERR;
    assign wr_addr = wr_addr_q;
    assign wr_data = wr_data_q;
    assign wr_strb = wr_strb_q;

    // ==============================
    // read side
    // ==============================
    assign ar_ready = (rd_state == RD_IDLE);
    assign ar_fire  = ar_valid && ar_ready;
    assign rd_ok    = (ar_len == LEN_SINGLE) && (ar_size == SIZE_DWORD) &&
                      (ar_burst == BURST_INCR) && (ar_id == ID_RAM || ar_id == ID_INST);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_state <= RD_IDLE;
            rd_legal <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        rd_state <= RD_ADDR;
                        rd_legal <= rd_ok;
                    end
                end
                RD_ADDR: rd_state <= RD_DATA;
                RD_DATA: if (r_valid && r_ready) rd_state <= RD_IDLE;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_id     <= ar_id;
            rd_addr_q <= ar_addr;
        end
    end

    assign rd_ram     = (rd_state == RD_DATA) && rd_legal && (rd_id == ID_RAM);
    assign rd_inst    = (rd_state == RD_DATA) && rd_legal && (rd_id == ID_INST);
    assign ram_rd_en  = rd_ram;
    assign inst_rd_en = rd_inst;
    assign rd_addr    = rd_addr_q;

    assign r_valid = (rd_state == RD_DATA);
    assign r_last  = (rd_state == RD_DATA);
    assign r_resp  = rd_legal ? RESP_OKAY : RESP_SLVERR;
    assign r_data  = rd_ram  ? ram_rdata :
                     rd_inst ? {{(DATA_W-INST_W){1'b0}}, inst_rdata} :  // zero extend
                     '0;

endmodule

// ==== source/mem_array.sv ====
module mem_array (
    input  logic               clk,

    // read side
    input  logic               ram_rd_en,
    input  logic               inst_rd_en,
    input  axi_mem_pkg::addr_t rd_addr,
    output axi_mem_pkg::data_t ram_rdata,
    output axi_mem_pkg::inst_t inst_rdata,

    // write side
    input  logic               ram_wr_en,
    input  axi_mem_pkg::addr_t wr_addr,
    input  axi_mem_pkg::data_t wr_data,
    input  axi_mem_pkg::strb_t wr_strb
);
    import axi_mem_pkg::*;

    data_t                 ram_mem  [RAM_WORDS];
    inst_t                 inst_mem [INST_WORDS];
    logic [RAM_IDX_W-1:0]  ram_wr_idx;
    logic [RAM_IDX_W-1:0]  ram_rd_idx;
    logic [INST_IDX_W-1:0] inst_rd_idx;

    // ==============================
    // data RAM
    // ==============================
    assign ram_wr_idx = wr_addr[RAM_LSB +: RAM_IDX_W];  // upper bits ignored
    assign ram_rd_idx = rd_addr[RAM_LSB +: RAM_IDX_W];

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ram_wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wr_strb[b]) begin
                    ram_mem[ram_wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    assign ram_rdata = ram_rd_en ? ram_mem[ram_rd_idx] : '0;

    // ==============================
    // instruction memory
    // ==============================
    assign inst_rd_idx = rd_addr[INST_LSB +: INST_IDX_W];

    initial begin
        $readmemh("testbench/inst.hex", inst_mem);
    end

    assign inst_rdata = inst_rd_en ? inst_mem[inst_rd_idx] : '0;

endmodule

// ==== source/axi_mem_top.sv ====
module axi_mem_top (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   req,
    input  logic                   req_write,
    input  axi_mem_pkg::axi_id_t   req_id,
    input  axi_mem_pkg::axi_size_t req_size,
    input  axi_mem_pkg::addr_t     req_addr,
    input  axi_mem_pkg::data_t     req_wdata,
    input  axi_mem_pkg::strb_t     req_strb,
    output logic                   busy,
    output logic                   done,
    output axi_mem_pkg::data_t     rdata,
    output axi_mem_pkg::axi_resp_t resp
);
    import axi_mem_pkg::*;

    // ==============================
    // AXI wires
    // ==============================
    axi_id_t    aw_id,    ar_id;
    addr_t      aw_addr,  ar_addr;
    axi_len_t   aw_len,   ar_len;
    axi_size_t  aw_size,  ar_size;
    axi_burst_t aw_burst, ar_burst;
    logic       aw_valid, aw_ready, ar_valid, ar_ready;
    data_t      w_data,   r_data;
    strb_t      w_strb;
    logic       w_last,   w_valid,  w_ready;
    axi_resp_t  b_resp,   r_resp;
    logic       b_valid,  b_ready;
    logic       r_last,   r_valid,  r_ready;

    // memory wires
    logic       ram_rd_en, inst_rd_en, ram_wr_en;
    addr_t      rd_addr,   wr_addr;
    data_t      ram_rdata, wr_data;
    inst_t      inst_rdata;
    strb_t      wr_strb;

    core_axi_bridge bridge0 (
        .clk, .rst,
        .req, .req_write, .req_id, .req_size, .req_addr, .req_wdata, .req_strb,
        .busy, .done, .rdata, .resp,
        .aw_id, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_last, .w_valid, .w_ready,
        .b_resp, .b_valid, .b_ready,
        .ar_id, .ar_addr, .ar_len, .ar_size, .ar_burst, .ar_valid, .ar_ready,
        .r_data, .r_resp, .r_last, .r_valid, .r_ready
    );

    axi_mem_slave slave0 (
        .clk, .rst,
        .aw_id, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
        .w_data, .w_strb, .w_last, .w_valid, .w_ready,
        .b_resp, .b_valid, .b_ready,
        .ar_id, .ar_addr, .ar_len, .ar_size, .ar_burst, .ar_valid, .ar_ready,
        .r_data, .r_resp, .r_last, .r_valid, .r_ready,
        .ram_rd_en, .inst_rd_en, .rd_addr, .ram_rdata, .inst_rdata,
        .ram_wr_en, .wr_addr, .wr_data, .wr_strb
    );

    mem_array mem0 (
        .clk,
        .ram_rd_en, .inst_rd_en, .rd_addr, .ram_rdata, .inst_rdata,
        .ram_wr_en, .wr_addr, .wr_data, .wr_strb
    );

endmodule

// ==== testbench/tb_axi_mem_top.sv ====
module tb_axi_mem_top;
    import axi_mem_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;

    logic      clk;
    logic      rst;
    logic      req;
    logic      req_write;
    axi_id_t   req_id;
    axi_size_t req_size;
    addr_t     req_addr;
    data_t     req_wdata;
    strb_t     req_strb;
    logic      busy;
    logic      done;
    data_t     rdata;
    axi_resp_t resp;

    data_t       ram_model  [RAM_WORDS];
    inst_t       inst_model [INST_WORDS];
    logic [31:0] lcg_state;
    string       test_name;
    int          err_count;
    int          err_at_start;
    int          tests_passed;
    int          tests_failed;

    axi_mem_top dut0 (
        .clk, .rst,
        .req, .req_write, .req_id, .req_size, .req_addr, .req_wdata, .req_strb,
        .busy, .done, .rdata, .resp
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];  // strobed lane takes new byte
        end
        return merged;
    endfunction

    task automatic compare_data(string name, data_t expected, data_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_resp(string name, axi_resp_t expected, axi_resp_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_count(string name, int expected, int actual);
        if (expected != actual) begin
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic begin_test(string name);
        test_name    = name;
        err_at_start = err_count;
    endtask

    task automatic end_test();
        if (err_count == err_at_start) begin
            $display("%s: ok", test_name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", test_name, err_count - err_at_start);
            tests_failed++;
        end
    endtask

    task automatic drive_req(logic write, axi_id_t id, axi_size_t size, addr_t addr,
                             data_t wdata, strb_t strb);
        req       = 1'b1;
        req_write = write;
        req_id    = id;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        req_strb  = strb;
    endtask

    // one request, waits for done; lat counts edges from req to done
    task automatic do_request(input logic write, input axi_id_t id, input axi_size_t size,
                              input addr_t addr, input data_t wdata, input strb_t strb,
                              output data_t rd, output axi_resp_t rs, output int lat);
        int cycles;
        int busy_low;
        drive_req(write, id, size, addr, wdata, strb);
        @(posedge clk);
        #2;
        req      = 1'b0;
        cycles   = 1;
        busy_low = 0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            if (!busy) busy_low++;  // busy must cover the whole wait
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!done) begin
            $display("%s: no done within %0d cycles of the request", test_name, TIMEOUT_CYCLES);
            err_count++;
            cycles = -1;
        end else begin
            compare_count(test_name, 0, busy_low);
            compare_count(test_name, 0, int'(busy));
        end
        rd  = rdata;
        rs  = resp;
        lat = cycles;
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic ram_write_read();
        data_t     rd;
        axi_resp_t rs;
        int        lat;
        begin_test("ram_write_read");
        do_request(1'b1, ID_RAM, SIZE_DWORD, 64'h40, 64'h0123_4567_89ab_cdef, 8'hff, rd, rs, lat);
        ram_model[8] = 64'h0123_4567_89ab_cdef;
        compare_resp(test_name, RESP_OKAY, rs);
        compare_count(test_name, 4, lat);
        do_request(1'b0, ID_RAM, SIZE_DWORD, 64'h40, '0, '0, rd, rs, lat);
        compare_resp(test_name, RESP_OKAY, rs);
        compare_data(test_name, ram_model[8], rd);
        compare_count(test_name, 4, lat);
        end_test();
    endtask

    task automatic byte_strobe();
        data_t     rd;
        axi_resp_t rs;
        int        lat;
        begin_test("byte_strobe");
        do_request(1'b1, ID_RAM, SIZE_DWORD, 64'ha0, 64'h1122_3344_5566_7788, 8'hff, rd, rs, lat);
        ram_model[20] = 64'h1122_3344_5566_7788;
        do_request(1'b1, ID_RAM, SIZE_DWORD, 64'ha0, 64'haabb_ccdd_eeff_0011, 8'ha5, rd, rs, lat);
        ram_model[20] = merge_bytes(ram_model[20], 64'haabb_ccdd_eeff_0011, 8'ha5);
        compare_resp(test_name, RESP_OKAY, rs);
        do_request(1'b0, ID_RAM, SIZE_DWORD, 64'ha0, '0, '0, rd, rs, lat);
        compare_resp(test_name, RESP_OKAY, rs);
        compare_data(test_name, ram_model[20], rd);
        end_test();
    endtask

    task automatic inst_fetch();
        addr_t     fetch_addr [5] = '{64'h0, 64'h4, 64'h3c, 64'hfc, 64'h1000_0104};
        data_t     rd;
        axi_resp_t rs;
        int        lat;
        begin_test("inst_fetch");
        for (int i = 0; i < 5; i++) begin
            do_request(1'b0, ID_INST, SIZE_DWORD, fetch_addr[i], '0, '0, rd, rs, lat);
            compare_resp(test_name, RESP_OKAY, rs);
            compare_data(test_name, {32'h0, inst_model[fetch_addr[i][7:2]]}, rd);
        end
        end_test();
    endtask

    task automatic illegal_access();
        data_t     rd;
        axi_resp_t rs;
        int        lat;
        begin_test("illegal_access");
        do_request(1'b0, ID_RAM, 3'd2, 64'h40, '0, '0, rd, rs, lat);
        compare_resp(test_name, RESP_SLVERR, rs);
        compare_data(test_name, '0, rd);
        do_request(1'b1, ID_RAM, 3'd2, 64'h40, 64'hffff_ffff_ffff_ffff, 8'hff, rd, rs, lat);
        compare_resp(test_name, RESP_SLVERR, rs);
        do_request(1'b1, ID_INST, SIZE_DWORD, 64'h40, 64'h5555_aaaa_5555_aaaa, 8'hff,
                   rd, rs, lat);
        compare_resp(test_name, RESP_SLVERR, rs);
        do_request(1'b0, ID_RAM, SIZE_DWORD, 64'h40, '0, '0, rd, rs, lat);  // still old word
        compare_resp(test_name, RESP_OKAY, rs);
        compare_data(test_name, ram_model[8], rd);
        end_test();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [7:0]  idx;
        addr_t       addr;
        data_t       wdata;
        strb_t       strb;
        data_t       rd;
        axi_resp_t   rs;
        int          lat;
        begin_test("random_traffic");
        for (int i = 0; i < 40; i++) begin
            r    = lcg_next();
            addr = {lcg_next(), lcg_next()};  // high bits ignored by the RAM
            addr[10:7] = 4'b0001;  // 16-word window so reads hit written words
            idx  = addr[10:3];
            if (r[31]) begin
                wdata = {lcg_next(), lcg_next()};
                strb  = r[23:16];
                do_request(1'b1, ID_RAM, SIZE_DWORD, addr, wdata, strb, rd, rs, lat);
                ram_model[idx] = merge_bytes(ram_model[idx], wdata, strb);
                compare_resp(test_name, RESP_OKAY, rs);
            end else begin
                do_request(1'b0, ID_RAM, SIZE_DWORD, addr, '0, '0, rd, rs, lat);
                compare_resp(test_name, RESP_OKAY, rs);
                compare_data(test_name, ram_model[idx], rd);
            end
        end
        end_test();
    endtask

    task automatic busy_ignore();
        int        dones;
        int        busy_seen;
        data_t     rd;
        axi_resp_t rs;
        int        lat;
        begin_test("busy_ignore");
        dones = 0;
        drive_req(1'b1, ID_RAM, SIZE_DWORD, 64'h200, 64'hcafe_f00d_1234_5678, 8'hff);
        @(posedge clk);
        #2;
        busy_seen = int'(busy);
        drive_req(1'b1, ID_RAM, SIZE_DWORD, 64'h208, 64'hdead_beef_dead_beef, 8'hff);
        @(posedge clk);
        #2;
        req = 1'b0;
        for (int c = 0; c < 12; c++) begin  // window covers one full transaction
            if (done) dones++;
            @(posedge clk);
            #2;
        end
        ram_model[64] = 64'hcafe_f00d_1234_5678;
        compare_count(test_name, 1, busy_seen);
        compare_count(test_name, 1, dones);
        do_request(1'b0, ID_RAM, SIZE_DWORD, 64'h200, '0, '0, rd, rs, lat);
        compare_data(test_name, ram_model[64], rd);
        do_request(1'b0, ID_RAM, SIZE_DWORD, 64'h208, '0, '0, rd, rs, lat);
        compare_data(test_name, ram_model[65], rd);
        end_test();
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        rst          = 1'b0;
        req          = 1'b0;
        req_write    = 1'b0;
        req_id       = '0;
        req_size     = '0;
        req_addr     = '0;
        req_wdata    = '0;
        req_strb     = '0;
        lcg_state    = 32'h323ecab0;
        err_count    = 0;
        err_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "reset";
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i] = '0;
        end
        $readmemh("testbench/inst.hex", inst_model);
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b1;
        @(posedge clk);
        #2;
        ram_write_read();
        byte_strobe();
        inst_fetch();
        illegal_access();
        random_traffic();
        busy_ignore();
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (err_count == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/inst.hex ====
// one 32-bit instruction word per line, word index 0 to 63
00000013
00100093
00200113
00308193
00410213
00518293
00620313
00728393
00830413
00938493
00a40513
00b48593
00c50613
00d58693
00e60713
00f68793
002081b3
40110233
003142b3
00419333
0051d3b3
0062e433
0073f4b3
00812023
00913423
00a12823
00b12c23
00012503
00412583
00812603
00c12683
fe010113
00113c23
00813823
00913423
01010413
fea42623
fec42783
00178793
fef42623
fec42703
00900793
fee7d4e3
00000517
01050513
0000006f
00008067
02010113
01813083
01013403
00813483
00a00893
00000073
00100073
30200073
10500073
0ff0000f
0000100f
34011073
34202573
30529073
12345037
abcde0b7
deadc137

// ==== project.f ====
source/axi_mem_pkg.sv
source/core_axi_bridge.sv
source/axi_mem_slave.sv
source/mem_array.sv
source/axi_mem_top.sv
testbench/tb_axi_mem_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run from the project root so the hex path resolves
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_axi_mem_top \
    -o tb_axi_mem_top > build.log 2>&1 &&
./obj_dir/tb_axi_mem_top > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "STATUS: PASS" sim.log && exit 0 || exit 1
